// File: logic/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// bank count must be a power of two
`define NUM_BANKS   4
`define BANK_WORDS  256

`define AXI_ID_W    4

// derived index widths
`define BANK_SEL_W  $clog2(`NUM_BANKS)
`define WORD_IDX_W  $clog2(`BANK_WORDS)

`endif

// File: logic/axi_pkg.sv
`include "mem_cfg.svh"

package axi_pkg;

    typedef logic [31:0] axi_word_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    typedef logic [3:0] beat_len_t;             // beats minus one

    localparam int TAG_W = 32 - `WORD_IDX_W - `BANK_SEL_W - 2;

    // byte address split for word interleaving
    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic [`WORD_IDX_W-1:0] idx;            // word within bank
        logic [`BANK_SEL_W-1:0] bank;
        logic [1:0]             offset;
    } axi_addr_s;

    typedef union packed {
        axi_word_t flat;
        axi_addr_s f;
    } axi_addr_u;

endpackage

// File: logic/axi3_if.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

interface axi3_if import axi_pkg::*; ();

    logic [`AXI_ID_W-1:0] arid;
    axi_word_t            araddr;
    beat_len_t            arlen;
    logic [2:0]           arsize;
    axi_burst_t           arburst;
    logic                 arvalid;
    logic                 arready;

    logic [`AXI_ID_W-1:0] rid;
    axi_word_t            rdata;
    logic                 rlast;
    logic                 rvalid;
    logic                 rready;

    logic [`AXI_ID_W-1:0] awid;
    axi_word_t            awaddr;
    beat_len_t            awlen;
    logic [2:0]           awsize;
    axi_burst_t           awburst;
    logic                 awvalid;
    logic                 awready;

    axi_word_t            wdata;
    logic [3:0]           wstrb;
    logic                 wlast;
    logic                 wvalid;
    logic                 wready;

    logic [`AXI_ID_W-1:0] bid;
    logic                 bvalid;
    logic                 bready;

    modport master (
        output arid, araddr, arlen, arsize, arburst, arvalid, rready,
        output awid, awaddr, awlen, awsize, awburst, awvalid,
        output wdata, wstrb, wlast, wvalid, bready,
        input  arready, rid, rdata, rlast, rvalid, awready, wready, bid, bvalid
    );

    modport slave (
        input  arid, araddr, arlen, arsize, arburst, arvalid, rready,
        input  awid, awaddr, awlen, awsize, awburst, awvalid,
        input  wdata, wstrb, wlast, wvalid, bready,
        output arready, rid, rdata, rlast, rvalid, awready, wready, bid, bvalid
    );

endinterface

// File: logic/bank_if.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

interface bank_if import axi_pkg::*; ();

    logic [`NUM_BANKS-1:0]  en;                 // one-hot bank select
    logic                   we;
    logic [`WORD_IDX_W-1:0] idx;
    axi_word_t              wdata;
    logic [3:0]             wstrb;
    axi_word_t              rdata [`NUM_BANKS];
    logic [`AXI_ID_W-1:0]   id;
    logic                   last;
    logic                   can_accept;         // read buffer has room

    modport ctrl  (output en, we, idx, wdata, wstrb, id, last, input can_accept);
    modport bank  (input en, we, idx, wdata, wstrb, output rdata);
    modport drain (input en, we, rdata, id, last, output can_accept);

endinterface

// File: logic/cpu_axi_arbiter.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cpu_axi_arbiter import axi_pkg::*; (
    input  axi_word_t  i_ifetch_araddr,
    input  axi_burst_t i_ifetch_arburst,
    input  logic [7:0] i_ifetch_arlen,
    input  logic       i_ifetch_arvalid,
    output logic       o_ifetch_arready,
    output axi_word_t  o_ifetch_rdata,
    output logic       o_ifetch_rlast,
    output logic       o_ifetch_rvalid,
    input  logic       i_ifetch_rready,

    input  axi_word_t  i_data_araddr,
    input  logic [7:0] i_data_arlen,
    input  logic [2:0] i_data_arsize,
    input  logic       i_data_arvalid,
    output logic       o_data_arready,
    output axi_word_t  o_data_rdata,
    output logic       o_data_rlast,
    output logic       o_data_rvalid,
    input  logic       i_data_rready,

    input  axi_word_t  i_data_awaddr,
    input  logic [7:0] i_data_awlen,
    input  logic [2:0] i_data_awsize,
    input  logic       i_data_awvalid,
    output logic       o_data_awready,
    input  axi_word_t  i_data_wdata,
    input  logic [3:0] i_data_wstrb,
    input  logic       i_data_wlast,
    input  logic       i_data_wvalid,
    output logic       o_data_wready,
    output logic       o_data_bvalid,
    input  logic       i_data_bready,

    axi3_if.master     axi
);

    logic raddr_sel;                            // data read gets AR only when fetch is quiet
    logic rdata_sel;

    assign raddr_sel = !i_ifetch_arvalid && i_data_arvalid;
    assign rdata_sel = axi.rid[0];

    assign o_ifetch_arready = axi.arready && !raddr_sel;
    assign o_ifetch_rdata   = !rdata_sel ? axi.rdata  : '0;
    assign o_ifetch_rlast   = !rdata_sel ? axi.rlast  : 1'b0;
    assign o_ifetch_rvalid  = !rdata_sel ? axi.rvalid : 1'b0;

    assign o_data_arready   = axi.arready && raddr_sel;
    assign o_data_rdata     = rdata_sel ? axi.rdata  : '0;
    assign o_data_rlast     = rdata_sel ? axi.rlast  : 1'b0;
    assign o_data_rvalid    = rdata_sel ? axi.rvalid : 1'b0;

    assign axi.arid    = {{(`AXI_ID_W-1){1'b0}}, raddr_sel};
    assign axi.araddr  = raddr_sel ? i_data_araddr : i_ifetch_araddr;
    assign axi.arlen   = raddr_sel ? i_data_arlen[3:0] : i_ifetch_arlen[3:0];
    assign axi.arsize  = raddr_sel ? i_data_arsize : 3'b010;    // fetch is always a word
    assign axi.arburst = raddr_sel ? BURST_WRAP : i_ifetch_arburst;
    assign axi.arvalid = raddr_sel ? i_data_arvalid : i_ifetch_arvalid;
    assign axi.rready  = rdata_sel ? i_data_rready : i_ifetch_rready;

    // writes come only from the data port
    assign axi.awid    = '0;
    assign axi.awaddr  = i_data_awaddr;
    assign axi.awlen   = i_data_awlen[3:0];
    assign axi.awsize  = i_data_awsize;
    assign axi.awburst = BURST_WRAP;
    assign axi.awvalid = i_data_awvalid;
    assign axi.wdata   = i_data_wdata;
    assign axi.wstrb   = i_data_wstrb;
    assign axi.wlast   = i_data_wlast;
    assign axi.wvalid  = i_data_wvalid;
    assign axi.bready  = i_data_bready;

    assign o_data_awready = axi.awready;
    assign o_data_wready  = axi.wready;
    assign o_data_bvalid  = axi.bvalid;

endmodule

// File: logic/axi_burst_ctrl.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module axi_burst_ctrl import axi_pkg::*; (
    input  logic   clk,
    input  logic   i_reset,
    axi3_if.slave  axi,
    bank_if.ctrl   banks
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_RESP
    } state_t;

    state_t               state;
    axi_addr_u            addr_q;
    beat_len_t            len_q;
    beat_len_t            beat_q;
    axi_burst_t           burst_q;
    logic [1:0]           size_q;
    logic [`AXI_ID_W-1:0] id_q;

    logic [`NUM_BANKS-1:0] bank_hit;
    logic [31:0]           step;
    logic [31:0]           wrap_mask;
    axi_word_t             incr_addr;
    axi_word_t             next_addr;
    logic                  last_beat;
    logic                  rd_go;
    logic                  wr_go;

    // sizes above a word still move one word per beat
    function automatic logic [1:0] word_size(input logic [2:0] size);
        return (size > 3'd2) ? 2'd2 : size[1:0];
    endfunction

    assign axi.arready = (state == S_IDLE);
    assign axi.awready = (state == S_IDLE) && !axi.arvalid;   // AR wins in idle
    assign axi.wready  = (state == S_WRITE);
    assign axi.bvalid  = (state == S_RESP);
    assign axi.bid     = id_q;

    assign rd_go     = (state == S_READ) && banks.can_accept;
    assign wr_go     = axi.wvalid && axi.wready;
    assign last_beat = (beat_q == len_q);

    // burst address arithmetic on the flat view
    assign step      = 32'd1 << size_q;
    assign wrap_mask = (({28'd0, len_q} + 32'd1) << size_q) - 32'd1;
    assign incr_addr = addr_q.flat + step;
    assign next_addr = (burst_q == BURST_WRAP) ?
                       ((addr_q.flat & ~wrap_mask) | (incr_addr & wrap_mask)) : incr_addr;

    // bank select from the field view
    assign bank_hit    = {{(`NUM_BANKS-1){1'b0}}, 1'b1} << addr_q.f.bank;
    assign banks.en    = (rd_go || wr_go) ? bank_hit : '0;
    assign banks.we    = (state == S_WRITE);
    assign banks.idx   = addr_q.f.idx;
    assign banks.wdata = axi.wdata;
    assign banks.wstrb = axi.wstrb;
    assign banks.id    = id_q;
    assign banks.last  = last_beat;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (axi.arvalid)
                        state <= S_READ;
                    else if (axi.awvalid)
                        state <= S_WRITE;
                end
                S_READ:  if (rd_go && last_beat) state <= S_IDLE;
                S_WRITE: if (wr_go && axi.wlast) state <= S_RESP;
                S_RESP:  if (axi.bready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            beat_q <= '0;
            if (axi.arvalid) begin
                addr_q.flat <= axi.araddr;
                len_q       <= axi.arlen;
                burst_q     <= axi.arburst;
                size_q      <= word_size(axi.arsize);
                id_q        <= axi.arid;
            end else if (axi.awvalid) begin
                addr_q.flat <= axi.awaddr;
                len_q       <= axi.awlen;
                burst_q     <= axi.awburst;
                size_q      <= word_size(axi.awsize);
                id_q        <= axi.awid;
            end
        end else if (rd_go || wr_go) begin
            addr_q.flat <= next_addr;           // FIXED falls through as INCR
            beat_q      <= beat_q + 4'd1;
        end
    end

endmodule

// File: logic/mem_bank.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_bank import axi_pkg::*; #(
    parameter int BANK_ID = 0
) (
    input  logic  clk,
    bank_if.bank  bus
);

    axi_word_t mem [`BANK_WORDS];

    always_ff @(posedge clk) begin
        if (bus.en[BANK_ID]) begin
            if (bus.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus.wstrb[b])
                        mem[bus.idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end else begin
                bus.rdata[BANK_ID] <= mem[bus.idx];     // holds until next read
            end
        end
    end

endmodule

// File: logic/r_beat_buffer.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module r_beat_buffer import axi_pkg::*; (
    input  logic   clk,
    input  logic   i_reset,
    bank_if.drain  banks,
    axi3_if.slave  axi
);

    logic                   rd_issue;
    logic [`BANK_SEL_W-1:0] issue_bank;
    logic                   pend_valid;         // bank data lands this cycle
    logic [`BANK_SEL_W-1:0] pend_bank;
    logic [`AXI_ID_W-1:0]   pend_id;
    logic                   pend_last;
    axi_word_t              pend_data;

    axi_word_t              fifo_data [2];
    logic [`AXI_ID_W-1:0]   fifo_id [2];
    logic                   fifo_last [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;

    logic                   fifo_empty;
    logic                   pop;
    logic                   fifo_pop;
    logic                   push;

    assign rd_issue = |banks.en && !banks.we;

    always_comb begin
        issue_bank = '0;
        for (int b = 0; b < `NUM_BANKS; b++) begin
            if (banks.en[b])
                issue_bank = b[`BANK_SEL_W-1:0];
        end
    end

    assign pend_data  = banks.rdata[pend_bank];
    assign fifo_empty = (count == 2'd0);

    // empty buffer passes the fresh beat straight out
    assign axi.rvalid = !fifo_empty || pend_valid;
    assign axi.rdata  = fifo_empty ? pend_data : fifo_data[rd_ptr];
    assign axi.rid    = fifo_empty ? pend_id   : fifo_id[rd_ptr];
    assign axi.rlast  = fifo_empty ? pend_last : fifo_last[rd_ptr];

    assign pop      = axi.rvalid && axi.rready;
    assign fifo_pop = pop && !fifo_empty;
    assign push     = pend_valid && !(pop && fifo_empty);

    assign banks.can_accept = ({1'b0, count} + {2'b00, pend_valid}) < 3'd2;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pend_valid <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
        end else begin
            pend_valid <= rd_issue;
            if (push)
                wr_ptr <= ~wr_ptr;
            if (fifo_pop)
                rd_ptr <= ~rd_ptr;
            case ({push, fifo_pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            pend_bank <= issue_bank;
            pend_id   <= banks.id;
            pend_last <= banks.last;
        end
        if (push) begin
            fifo_data[wr_ptr] <= pend_data;
            fifo_id[wr_ptr]   <= pend_id;
            fifo_last[wr_ptr] <= pend_last;
        end
    end

endmodule

// File: logic/cpu_mem_top.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cpu_mem_top import axi_pkg::*; (
    input  logic       clk,
    input  logic       i_reset,

    input  axi_word_t  i_ifetch_araddr,
    input  axi_burst_t i_ifetch_arburst,
    input  logic [7:0] i_ifetch_arlen,
    input  logic       i_ifetch_arvalid,
    output logic       o_ifetch_arready,
    output axi_word_t  o_ifetch_rdata,
    output logic       o_ifetch_rlast,
    output logic       o_ifetch_rvalid,
    input  logic       i_ifetch_rready,

    input  axi_word_t  i_data_araddr,
    input  logic [7:0] i_data_arlen,
    input  logic [2:0] i_data_arsize,
    input  logic       i_data_arvalid,
    output logic       o_data_arready,
    output axi_word_t  o_data_rdata,
    output logic       o_data_rlast,
    output logic       o_data_rvalid,
    input  logic       i_data_rready,

    input  axi_word_t  i_data_awaddr,
    input  logic [7:0] i_data_awlen,
    input  logic [2:0] i_data_awsize,
    input  logic       i_data_awvalid,
    output logic       o_data_awready,
    input  axi_word_t  i_data_wdata,
    input  logic [3:0] i_data_wstrb,
    input  logic       i_data_wlast,
    input  logic       i_data_wvalid,
    output logic       o_data_wready,
    output logic       o_data_bvalid,
    input  logic       i_data_bready
);

    axi3_if axi ();
    bank_if banks ();

    cpu_axi_arbiter u_arbiter (
        .i_ifetch_araddr  (i_ifetch_araddr),
        .i_ifetch_arburst (i_ifetch_arburst),
        .i_ifetch_arlen   (i_ifetch_arlen),
        .i_ifetch_arvalid (i_ifetch_arvalid),
        .o_ifetch_arready (o_ifetch_arready),
        .o_ifetch_rdata   (o_ifetch_rdata),
        .o_ifetch_rlast   (o_ifetch_rlast),
        .o_ifetch_rvalid  (o_ifetch_rvalid),
        .i_ifetch_rready  (i_ifetch_rready),
        .i_data_araddr    (i_data_araddr),
        .i_data_arlen     (i_data_arlen),
        .i_data_arsize    (i_data_arsize),
        .i_data_arvalid   (i_data_arvalid),
        .o_data_arready   (o_data_arready),
        .o_data_rdata     (o_data_rdata),
        .o_data_rlast     (o_data_rlast),
        .o_data_rvalid    (o_data_rvalid),
        .i_data_rready    (i_data_rready),
        .i_data_awaddr    (i_data_awaddr),
        .i_data_awlen     (i_data_awlen),
        .i_data_awsize    (i_data_awsize),
        .i_data_awvalid   (i_data_awvalid),
        .o_data_awready   (o_data_awready),
        .i_data_wdata     (i_data_wdata),
        .i_data_wstrb     (i_data_wstrb),
        .i_data_wlast     (i_data_wlast),
        .i_data_wvalid    (i_data_wvalid),
        .o_data_wready    (o_data_wready),
        .o_data_bvalid    (o_data_bvalid),
        .i_data_bready    (i_data_bready),
        .axi              (axi.master)
    );

    axi_burst_ctrl u_ctrl (
        .clk     (clk),
        .i_reset (i_reset),
        .axi     (axi.slave),
        .banks   (banks.ctrl)
    );

    for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
        mem_bank #(.BANK_ID(g)) u_bank (
            .clk (clk),
            .bus (banks.bank)
        );
    end

    r_beat_buffer u_rbuf (
        .clk     (clk),
        .i_reset (i_reset),
        .banks   (banks.drain),
        .axi     (axi.slave)
    );

endmodule

// File: tests/tb_cpu_mem.sv
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_cpu_mem import axi_pkg::*; ();

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_FETCH, OP_BOTH} op_t;

    typedef struct packed {
        op_t        op;
        axi_word_t  addr;
        int         len;                        // beats minus one
        axi_burst_t burst;                      // used by the fetch port only
        logic [3:0] strb;
        bit         rnd;                        // random rready on the R ports
    } test_t;

    localparam int MEM_WORDS = `NUM_BANKS * `BANK_WORDS;

    logic       clk;
    logic       i_reset;
    axi_word_t  i_ifetch_araddr;
    axi_burst_t i_ifetch_arburst;
    logic [7:0] i_ifetch_arlen;
    logic       i_ifetch_arvalid;
    logic       o_ifetch_arready;
    axi_word_t  o_ifetch_rdata;
    logic       o_ifetch_rlast;
    logic       o_ifetch_rvalid;
    logic       i_ifetch_rready;
    axi_word_t  i_data_araddr;
    logic [7:0] i_data_arlen;
    logic [2:0] i_data_arsize;
    logic       i_data_arvalid;
    logic       o_data_arready;
    axi_word_t  o_data_rdata;
    logic       o_data_rlast;
    logic       o_data_rvalid;
    logic       i_data_rready;
    axi_word_t  i_data_awaddr;
    logic [7:0] i_data_awlen;
    logic [2:0] i_data_awsize;
    logic       i_data_awvalid;
    logic       o_data_awready;
    axi_word_t  i_data_wdata;
    logic [3:0] i_data_wstrb;
    logic       i_data_wlast;
    logic       i_data_wvalid;
    logic       o_data_wready;
    logic       o_data_bvalid;
    logic       i_data_bready;

    string       test_name [$];
    test_t       tests [$];
    axi_word_t   ref_mem [MEM_WORDS];           // expected memory contents
    logic [31:0] rng;
    int          cyc = 0;
    int          err_value = 0;
    int          err_other = 0;
    bit          busy [2];                      // open read per port with fetch at index 1
    int          first_cyc [2];
    int          last_cyc [2];

    cpu_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // a port may only show rvalid while a read of its own is open
    always @(posedge clk) begin
        #2;
        if (o_ifetch_rvalid && !busy[1])
            note_failure("fetch R port shows rvalid with no fetch read in flight");
        if (o_data_rvalid && !busy[0])
            note_failure("data R port shows rvalid with no data read in flight");
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte address of beat k in an INCR or WRAP burst
    function automatic axi_word_t beat_addr(input axi_word_t start, input int len,
                                            input axi_burst_t burst, input int k);
        axi_word_t span;
        axi_word_t base;
        if (burst != BURST_WRAP)
            return start + 32'(4 * k);
        span = 32'((len + 1) * 4);
        base = start - (start % span);
        return base + ((start - base + 32'(4 * k)) % span);
    endfunction

    function automatic int word_idx(input axi_word_t a);
        return int'(a[31:2]) % MEM_WORDS;
    endfunction

    task automatic check_word(input string what, input axi_word_t exp, input axi_word_t act);
        if (act !== exp) begin
            err_value++;
            $display("** Error %s: expected %h, actual %h", what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input bit exp, input logic act);
        if (act !== exp) begin
            err_value++;
            $display("** Error %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        err_other++;
        $display("Failure: %s", msg);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic add_test(input string name, input op_t op, input axi_word_t addr,
                            input int len, input axi_burst_t burst, input logic [3:0] strb,
                            input bit rnd);
        test_t t;
        t.op    = op;
        t.addr  = addr;
        t.len   = len;
        t.burst = burst;
        t.strb  = strb;
        t.rnd   = rnd;
        test_name.push_back(name);
        tests.push_back(t);
    endtask

    task automatic load_table();
        add_test("fill_0",        OP_WR,    32'h000, 15, BURST_WRAP, 4'hf,    1'b0);
        add_test("fill_1",        OP_WR,    32'h040, 15, BURST_WRAP, 4'hf,    1'b0);
        add_test("fill_2",        OP_WR,    32'h080, 15, BURST_WRAP, 4'hf,    1'b0);
        add_test("fill_3",        OP_WR,    32'h0c0, 15, BURST_WRAP, 4'hf,    1'b0);
        add_test("wr_wrap4_mid",  OP_WR,    32'h018, 3,  BURST_WRAP, 4'b0101, 1'b0);
        add_test("wr_wrap8_mid",  OP_WR,    32'h0a4, 7,  BURST_WRAP, 4'b1100, 1'b0);
        add_test("wr_single",     OP_WR,    32'h0f0, 0,  BURST_WRAP, 4'b0010, 1'b0);
        add_test("wr_wrap2",      OP_WR,    32'h034, 1,  BURST_WRAP, 4'b1001, 1'b0);
        add_test("rd_wrap4_mid",  OP_RD,    32'h018, 3,  BURST_WRAP, 4'hf,    1'b0);
        add_test("rd_wrap8_mid",  OP_RD,    32'h0ac, 7,  BURST_WRAP, 4'hf,    1'b0);
        add_test("rd_single",     OP_RD,    32'h0f0, 0,  BURST_WRAP, 4'hf,    1'b0);
        add_test("rd_wrap2",      OP_RD,    32'h030, 1,  BURST_WRAP, 4'hf,    1'b0);
        add_test("fetch_incr16",  OP_FETCH, 32'h000, 15, BURST_INCR, 4'hf,    1'b0);
        add_test("fetch_incr6",   OP_FETCH, 32'h0a4, 5,  BURST_INCR, 4'hf,    1'b0);
        add_test("fetch_wrap4",   OP_FETCH, 32'h038, 3,  BURST_WRAP, 4'hf,    1'b0);
        add_test("both_reads",    OP_BOTH,  32'h044, 7,  BURST_INCR, 4'hf,    1'b0);
        add_test("rnd_rd_wrap16", OP_RD,    32'h0c8, 15, BURST_WRAP, 4'hf,    1'b1);
        add_test("rnd_fetch_12",  OP_FETCH, 32'h010, 11, BURST_INCR, 4'hf,    1'b1);
        add_test("rnd_both",      OP_BOTH,  32'h020, 7,  BURST_INCR, 4'hf,    1'b1);
        add_test("wr_wrap16_mid", OP_WR,    32'h08c, 15, BURST_WRAP, 4'b0110, 1'b0);
        add_test("rnd_rd_after",  OP_RD,    32'h08c, 15, BURST_WRAP, 4'hf,    1'b1);
    endtask

    task automatic run_write(input string name, input axi_word_t addr, input int len,
                             input logic [3:0] strb);
        axi_word_t d;
        int        idx;
        tick();
        i_data_awaddr  = addr;
        i_data_awlen   = 8'(len);
        i_data_awsize  = 3'd2;
        i_data_awvalid = 1'b1;
        i_data_bready  = 1'b1;
        #2;
        while (!o_data_awready) begin
            tick();
            #2;
        end
        tick();
        i_data_awvalid = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            rng           = lcg(rng);
            d             = rng;
            i_data_wdata  = d;
            i_data_wstrb  = strb;
            i_data_wlast  = (beat == len);
            i_data_wvalid = 1'b1;
            #2;
            check_flag($sformatf("%s wready beat %0d", name, beat), 1'b1, o_data_wready);
            while (!o_data_wready) begin
                tick();
                #2;
            end
            check_flag($sformatf("%s bvalid before wlast", name), 1'b0, o_data_bvalid);
            idx = word_idx(beat_addr(addr, len, BURST_WRAP, beat));   // data port wraps
            for (int b = 0; b < 4; b++) begin
                if (strb[b])
                    ref_mem[idx][8*b +: 8] = d[8*b +: 8];
            end
            tick();
        end
        i_data_wvalid = 1'b0;
        i_data_wlast  = 1'b0;
        #2;
        check_flag($sformatf("%s bvalid after wlast", name), 1'b1, o_data_bvalid);
        while (!o_data_bvalid) begin
            tick();
            #2;
        end
        tick();
        i_data_bready = 1'b0;
    endtask

    task automatic run_read(input string name, input bit fetch, input axi_word_t addr,
                            input int len, input axi_burst_t burst, input bit rnd,
                            input bit both, input logic [31:0] seed);
        logic [31:0] rs;
        int          ar_cyc;
        int          beat;
        bit          rdy;
        logic        vld;
        logic        last;
        axi_word_t   data;
        rs = seed;
        tick();
        if (fetch) begin
            i_ifetch_araddr  = addr;
            i_ifetch_arlen   = 8'(len);
            i_ifetch_arburst = burst;
            i_ifetch_arvalid = 1'b1;
        end else begin
            i_data_araddr  = addr;
            i_data_arlen   = 8'(len);
            i_data_arsize  = 3'd2;
            i_data_arvalid = 1'b1;
        end
        forever begin
            #2;
            if (!fetch && both && i_ifetch_arvalid)
                check_flag($sformatf("%s arready under fetch", name), 1'b0, o_data_arready);
            if (fetch ? o_ifetch_arready : o_data_arready)
                break;
            tick();
        end
        ar_cyc           = cyc;
        busy[fetch]      = 1'b1;
        first_cyc[fetch] = -1;
        beat             = 0;
        while (beat <= len) begin
            tick();
            if (fetch)
                i_ifetch_arvalid = 1'b0;
            else
                i_data_arvalid = 1'b0;
            rdy = !rnd || (rs[17:16] != 2'b00);
            rs  = lcg(rs);
            if (fetch)
                i_ifetch_rready = rdy;
            else
                i_data_rready = rdy;
            #2;
            vld  = fetch ? o_ifetch_rvalid : o_data_rvalid;
            last = fetch ? o_ifetch_rlast  : o_data_rlast;
            data = fetch ? o_ifetch_rdata  : o_data_rdata;
            if (vld && rdy) begin
                if (beat == 0)
                    first_cyc[fetch] = cyc;
                check_word($sformatf("%s beat %0d", name, beat),
                           ref_mem[word_idx(beat_addr(addr, len, burst, beat))], data);
                check_flag($sformatf("%s rlast beat %0d", name, beat), beat == len, last);
                if (!rnd && (fetch || !both) && cyc != ar_cyc + 2 + beat)
                    note_failure($sformatf("%s beat %0d came %0d cycles after AR, not %0d",
                                           name, beat, cyc - ar_cyc, 2 + beat));
                beat++;
            end
        end
        last_cyc[fetch] = cyc;
        busy[fetch]     = 1'b0;
        tick();
        if (fetch)
            i_ifetch_rready = 1'b0;
        else
            i_data_rready = 1'b0;
    endtask

    initial begin
        int          total_beats;
        int          limit_ns;
        logic [31:0] seed_f;
        logic [31:0] seed_d;
        test_t       t;
        i_reset          = 1'b1;
        i_ifetch_araddr  = '0;
        i_ifetch_arburst = BURST_INCR;
        i_ifetch_arlen   = '0;
        i_ifetch_arvalid = 1'b0;
        i_ifetch_rready  = 1'b0;
        i_data_araddr    = '0;
        i_data_arlen     = '0;
        i_data_arsize    = 3'd2;
        i_data_arvalid   = 1'b0;
        i_data_rready    = 1'b0;
        i_data_awaddr    = '0;
        i_data_awlen     = '0;
        i_data_awsize    = 3'd2;
        i_data_awvalid   = 1'b0;
        i_data_wdata     = '0;
        i_data_wstrb     = '0;
        i_data_wlast     = 1'b0;
        i_data_wvalid    = 1'b0;
        i_data_bready    = 1'b0;
        rng              = 32'd99455;
        load_table();
        total_beats = 0;
        foreach (tests[i])
            total_beats += (tests[i].len + 1) * ((tests[i].op == OP_BOTH) ? 2 : 1);
        limit_ns = total_beats * 20 * 4 + 1000;
        fork
            begin
                #(limit_ns);
                $display("watchdog expired after %0d ns with tests still running", limit_ns);
                $display("*** TEST FAILED ***");
                $finish;
            end
        join_none
        repeat (3) @(posedge clk);
        #1;
        i_reset = 1'b0;
        foreach (tests[i]) begin
            t      = tests[i];
            rng    = lcg(rng);
            seed_f = rng;
            rng    = lcg(rng);
            seed_d = rng;
            case (t.op)
                OP_WR:    run_write(test_name[i], t.addr, t.len, t.strb);
                OP_RD:    run_read(test_name[i], 1'b0, t.addr, t.len, BURST_WRAP, t.rnd,
                                   1'b0, seed_d);
                OP_FETCH: run_read(test_name[i], 1'b1, t.addr, t.len, t.burst, t.rnd,
                                   1'b0, seed_f);
                default: begin
                    fork
                        run_read({test_name[i], " fetch"}, 1'b1, t.addr, t.len, t.burst,
                                 t.rnd, 1'b1, seed_f);
                        run_read({test_name[i], " data"}, 1'b0, t.addr + 32'h40, t.len,
                                 BURST_WRAP, t.rnd, 1'b1, seed_d);
                    join
                    if (first_cyc[0] <= last_cyc[1])
                        note_failure($sformatf("%s data burst began before fetch burst ended",
                                               test_name[i]));
                end
            endcase
        end
        repeat (2) tick();
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
logic/axi_pkg.sv
logic/axi3_if.sv
logic/bank_if.sv
logic/cpu_axi_arbiter.sv
logic/axi_burst_ctrl.sv
logic/mem_bank.sv
logic/r_beat_buffer.sv
logic/cpu_mem_top.sv
tests/tb_cpu_mem.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_cpu_mem -o tb_cpu_mem \
    && out=$(./obj_dir/tb_cpu_mem)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
